// ==== dv/refr_cases.txt ====
// columns: gap_ok rst req a_vld a_bank b_vld b_bank cmd_vld cmd_bank ov_vld ov_bank
// overdue columns are expected in the cycle after the line.
0_0_0_0_0_0_0_0_0_0_0
0_0_1_0_0_0_0_1_0_0_0
0_0_1_0_0_0_0_1_1_0_0
0_0_1_0_0_0_0_1_2_0_0
0_0_1_0_0_0_0_1_3_0_0
0_0_1_0_0_0_0_1_4_0_0
0_0_1_0_0_0_0_1_5_0_0
0_0_1_0_0_0_0_1_6_0_0
0_0_1_0_0_0_0_1_7_0_0
0_0_1_0_0_0_0_1_8_0_0
0_0_1_0_0_0_0_1_9_0_0
0_0_1_0_0_0_0_1_a_0_0
0_0_1_0_0_0_0_1_b_0_0
0_0_1_0_0_0_0_1_c_0_0
0_0_1_0_0_0_0_1_d_0_0
0_0_1_0_0_0_0_1_e_0_0
0_0_1_0_0_0_0_1_f_0_0
1_0_1_0_0_0_0_1_0_0_0
1_1_0_0_0_0_0_0_0_0_0
0_0_1_1_0_0_0_1_1_0_0
0_0_1_1_0_0_0_1_2_0_0
0_0_1_0_0_0_0_1_0_0_0
1_0_1_0_0_0_0_1_3_0_0
0_0_1_1_4_1_5_1_6_0_0
0_0_1_1_4_1_5_1_7_0_0
0_0_1_0_0_0_0_1_4_0_0
0_0_1_0_0_0_0_1_5_0_0
1_0_1_0_0_0_0_1_8_0_0
1_1_0_0_0_0_0_0_0_0_0
0_0_1_1_0_0_0_1_1_0_0
0_0_1_1_0_0_0_1_2_0_0
0_0_1_1_0_0_0_1_3_0_0
0_0_1_1_0_0_0_1_4_0_0
0_0_1_1_0_0_0_1_5_0_0
0_0_1_1_0_0_0_1_6_0_0
0_0_1_1_0_0_0_1_7_0_0
0_0_1_1_0_0_0_1_8_0_0
0_0_1_1_0_0_0_1_9_0_0
0_0_1_1_0_0_0_1_a_0_0
0_0_1_1_0_0_0_1_b_0_0
0_0_1_1_0_0_0_1_c_0_0
0_0_1_1_0_0_0_1_d_0_0
0_0_1_1_0_0_0_1_e_0_0
0_0_1_1_0_0_0_1_f_0_0
0_0_1_1_0_0_0_0_0_0_0
0_0_1_1_0_0_0_0_0_0_0
0_0_1_1_0_0_0_0_0_0_0
0_0_1_1_0_0_0_0_0_0_0
1_0_1_1_0_0_0_0_0_1_0
1_1_0_0_0_0_0_0_0_0_0
0_0_1_0_0_0_0_1_0_0_0
0_0_1_0_0_0_0_1_1_0_0

// ==== dv/refr_checker.sv ====
module refr_checker
  import edram_refr_pkg::*;
(
  input  logic      clk,
  input  logic      active,
  input  refr_cmd_t exp_cmd,
  input  overdue_t  exp_ov_next,
  input  refr_cmd_t refr_cmd,
  input  overdue_t  overdue,
  output int        errors,
  output int        checks
);

  // overdue expected in the current cycle, set by the previous line.
  overdue_t ov_pend;

  initial begin
    errors  = 0;
    checks  = 0;
    ov_pend = '0;
  end

  always @(posedge clk) begin
    if (active) begin
      ov_pend <= exp_ov_next;
    end else begin
      ov_pend <= '0;
    end
  end

  // inputs change just after the rising edge, so the falling edge is stable.
  always @(negedge clk) begin
    if (active) begin
      checks = checks + 1;
      if (refr_cmd.vld !== exp_cmd.vld) begin
        $display("FAIL refr_cmd.vld: got %h expected %h",
                 refr_cmd.vld, exp_cmd.vld);
        errors = errors + 1;
      end else if (exp_cmd.vld && (refr_cmd.bank !== exp_cmd.bank)) begin
        $display("FAIL refr_cmd.bank: got %h expected %h",
                 refr_cmd.bank, exp_cmd.bank);
        errors = errors + 1;
      end

      if (overdue.vld !== ov_pend.vld) begin
        $display("FAIL overdue.vld: got %h expected %h",
                 overdue.vld, ov_pend.vld);
        errors = errors + 1;
      end else if (ov_pend.vld && (overdue.bank !== ov_pend.bank)) begin
        $display("FAIL overdue.bank: got %h expected %h",
                 overdue.bank, ov_pend.bank);
        errors = errors + 1;
      end
    end
  end

endmodule

// ==== dv/tb_edram_refr.sv ====
module tb_edram_refr
  import edram_refr_pkg::*;
();

  localparam int max_cases = 64;
  localparam int max_gap = 3;

  // one hex digit per field of a case line.
  typedef struct packed {
    logic [3:0] gap_ok;
    logic [3:0] rst;
    logic [3:0] req;
    logic [3:0] a_vld;
    logic [3:0] a_bank;
    logic [3:0] b_vld;
    logic [3:0] b_bank;
    logic [3:0] cmd_vld;
    logic [3:0] cmd_bank;
    logic [3:0] ov_vld;
    logic [3:0] ov_bank;
  } case_t;

  logic      clk;
  logic      rst;
  logic      refresh_req;
  bank_acc_t acc_a;
  bank_acc_t acc_b;
  refr_cmd_t refr_cmd;
  overdue_t  overdue;

  logic      active;
  refr_cmd_t exp_cmd;
  overdue_t  exp_ov_next;
  int        errors;
  int        checks;

  logic [43:0] case_mem [max_cases];
  int          num_cases;
  int          cycle_limit;
  int          cycles;

  edram_refr_ctrl u_edram_refr_ctrl (
    .clk         (clk),
    .rst         (rst),
    .refresh_req (refresh_req),
    .acc_a       (acc_a),
    .acc_b       (acc_b),
    .refr_cmd    (refr_cmd),
    .overdue     (overdue)
  );

  refr_checker u_checker (
    .clk         (clk),
    .active      (active),
    .exp_cmd     (exp_cmd),
    .exp_ov_next (exp_ov_next),
    .refr_cmd    (refr_cmd),
    .overdue     (overdue),
    .errors      (errors),
    .checks      (checks)
  );

  initial begin
    clk = 1'b0;
  end

  always begin
    #4 clk = ~clk;
  end

  task automatic drive_idle();
    rst         = 1'b0;
    refresh_req = 1'b0;
    acc_a       = '0;
    acc_b       = '0;
    exp_cmd     = '0;
    exp_ov_next = '0;
  endtask

  task automatic apply_case(input case_t c);
    rst         = c.rst[0];
    refresh_req = c.req[0];
    acc_a       = '{vld: c.a_vld[0], bank: c.a_bank};
    acc_b       = '{vld: c.b_vld[0], bank: c.b_bank};
    exp_cmd     = '{vld: c.cmd_vld[0], bank: c.cmd_bank};
    exp_ov_next = '{vld: c.ov_vld[0], bank: c.ov_bank};
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the case list did not finish", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    case_t cur;
    int    gap_lines;
    int    gap;

    void'($urandom(32'hf561));
    cycles      = 0;
    cycle_limit = 0;
    active      = 1'b0;
    drive_idle();
    rst = 1'b1;

    // top nibble f marks a slot the case file did not fill.
    for (int i = 0; i < max_cases; i++) begin
      case_mem[i] = {4'hf, 40'(i)};
    end
    $readmemh("dv/refr_cases.txt", case_mem);

    num_cases = 0;
    gap_lines = 0;
    while (num_cases < max_cases && case_mem[num_cases][43:40] != 4'hf) begin
      if (case_mem[num_cases][40]) begin
        gap_lines = gap_lines + 1;
      end
      num_cases = num_cases + 1;
    end
    cycle_limit = num_cases + gap_lines * max_gap + 20;

    repeat (2) @(posedge clk);
    #1;
    active = 1'b1;

    for (int i = 0; i < num_cases; i++) begin
      cur = case_t'(case_mem[i]);
      apply_case(cur);
      @(posedge clk);
      #1;
      if (cur.gap_ok[0] && i != num_cases - 1) begin
        gap = int'($urandom_range(max_gap, 0));
        repeat (gap) begin
          drive_idle();
          @(posedge clk);
          #1;
        end
      end
    end

    // one idle cycle lets the last overdue expectation be checked.
    drive_idle();
    @(posedge clk);
    @(posedge clk);
    #1;

    $display("checks: %0d  errors: %0d  cases: %0d", checks, errors, num_cases);
    if (num_cases == 0) begin
      $display("no case lines were read from the case file");
      $display("Some tests failed");
    end else if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
hdl/edram_refr_pkg.sv
hdl/refresh_scheduler.sv
hdl/retention_monitor.sv
hdl/edram_refr_ctrl.sv
dv/refr_checker.sv
dv/tb_edram_refr.sv

// ==== hdl/edram_refr_ctrl.sv ====
module edram_refr_ctrl
  import edram_refr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      refresh_req,
  input  bank_acc_t acc_a,
  input  bank_acc_t acc_b,
  output refr_cmd_t refr_cmd,
  output overdue_t  overdue
);

  // bank choice, same cycle as the request.
  refresh_scheduler u_sched (
    .clk         (clk),
    .rst         (rst),
    .refresh_req (refresh_req),
    .acc_a       (acc_a),
    .acc_b       (acc_b),
    .refr_cmd    (refr_cmd)
  );

  // ages every bank on each request.
  retention_monitor u_mon (
    .clk         (clk),
    .rst         (rst),
    .refresh_req (refresh_req),
    .refr_cmd    (refr_cmd),
    .overdue     (overdue)
  );

endmodule

// ==== hdl/edram_refr_pkg.sv ====
package edram_refr_pkg;

  localparam int num_banks = 16;
  localparam int bank_bits = 4;

  // requests a bank may miss before it is overdue.
  localparam int retention_limit = num_banks + 4;
  localparam int age_bits = 5;

  // one access port for the current cycle.
  typedef struct packed {
    logic                 vld;
    logic [bank_bits-1:0] bank;
  } bank_acc_t;

  // refresh issued to the macro.
  typedef struct packed {
    logic                 vld;
    logic [bank_bits-1:0] bank;
  } refr_cmd_t;

  // retention monitor report.
  typedef struct packed {
    logic                 vld;
    logic [bank_bits-1:0] bank;
  } overdue_t;

endpackage

// ==== hdl/refresh_scheduler.sv ====
`include "edram_refr_defs.svh"

module refresh_scheduler
  import edram_refr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      refresh_req,
  input  bank_acc_t acc_a,
  input  bank_acc_t acc_b,
  output refr_cmd_t refr_cmd
);

  typedef enum logic [2:0] {
    pick_none,
    pick_slot0,
    pick_slot1,
    pick_ptr,
    pick_ptr1,
    pick_ptr2
  } pick_e;

  function automatic logic [bank_bits-1:0] bank_add(
    input logic [bank_bits-1:0] b,
    input int unsigned          n
  );
    int unsigned sum;
    sum = (int'(b) + n) % num_banks;
    return bank_bits'(sum);
  endfunction

  // sweep state.
  logic [bank_bits-1:0] ptr;
  logic [bank_bits-1:0] ptr_p1;
  logic [bank_bits-1:0] ptr_p2;
  logic [bank_bits-1:0] ptr_p3;

  // stuck slots, slot 0 drains first.
  logic                 slot0_vld;
  logic [bank_bits-1:0] slot0_bank;
  logic                 slot1_vld;
  logic [bank_bits-1:0] slot1_bank;

  logic [bank_bits-1:0] ptr_nxt;
  logic                 slot0_vld_nxt;
  logic [bank_bits-1:0] slot0_bank_nxt;
  logic                 slot1_vld_nxt;
  logic [bank_bits-1:0] slot1_bank_nxt;

  logic [num_banks-1:0] blocked;
  logic                 p_stuck;
  pick_e                pick;

  assign ptr_p1 = bank_add(ptr, 1);
  assign ptr_p2 = bank_add(ptr, 2);
  assign ptr_p3 = bank_add(ptr, 3);

  // banks held by either port this cycle.
  always_comb begin
    blocked = '0;
    if (acc_a.vld) begin
      blocked[acc_a.bank] = 1'b1;
    end
    if (acc_b.vld) begin
      blocked[acc_b.bank] = 1'b1;
    end
  end

  assign p_stuck = (slot0_vld && (slot0_bank == ptr)) ||
                   (slot1_vld && (slot1_bank == ptr));

  // stuck banks first, then the pointer, then one or two ahead.
  always_comb begin
    if (slot0_vld && !blocked[slot0_bank]) begin
      pick = pick_slot0;
    end else if (slot1_vld && !blocked[slot1_bank]) begin
      pick = pick_slot1;
    end else if (!blocked[ptr]) begin
      pick = pick_ptr;
    end else if (!blocked[ptr_p1] && !p_stuck && !slot1_vld) begin
      pick = pick_ptr1;
    end else if (!blocked[ptr_p2] && !slot0_vld && !slot1_vld) begin
      pick = pick_ptr2;
    end else begin
      pick = pick_none;
    end
  end

  always_comb begin
    refr_cmd.vld = refresh_req && (pick != pick_none);
    case (pick)
      pick_slot0: refr_cmd.bank = slot0_bank;
      pick_slot1: refr_cmd.bank = slot1_bank;
      pick_ptr1:  refr_cmd.bank = ptr_p1;
      pick_ptr2:  refr_cmd.bank = ptr_p2;
      default:    refr_cmd.bank = ptr;
    endcase
  end

  always_comb begin
    ptr_nxt        = ptr;
    slot0_vld_nxt  = slot0_vld;
    slot0_bank_nxt = slot0_bank;
    slot1_vld_nxt  = slot1_vld;
    slot1_bank_nxt = slot1_bank;
    case (pick)
      pick_slot0: begin
        slot0_vld_nxt  = slot1_vld;
        slot0_bank_nxt = slot1_bank;
        slot1_vld_nxt  = 1'b0;
      end
      pick_slot1: begin
        slot1_vld_nxt = 1'b0;
      end
      pick_ptr: begin
        ptr_nxt = ptr_p1;
      end
      pick_ptr1: begin
        // skipped pointer bank goes to the first free slot.
        ptr_nxt = ptr_p2;
        if (!slot0_vld) begin
          slot0_vld_nxt  = 1'b1;
          slot0_bank_nxt = ptr;
        end else begin
          slot1_vld_nxt  = 1'b1;
          slot1_bank_nxt = ptr;
        end
      end
      pick_ptr2: begin
        ptr_nxt        = ptr_p3;
        slot0_vld_nxt  = 1'b1;
        slot0_bank_nxt = ptr;
        slot1_vld_nxt  = 1'b1;
        slot1_bank_nxt = ptr_p1;
      end
      default: begin
        ptr_nxt = ptr;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr       <= '0;
      slot0_vld <= 1'b0;
      slot1_vld <= 1'b0;
    end else if (refresh_req) begin
      ptr       <= ptr_nxt;
      slot0_vld <= slot0_vld_nxt;
      slot1_vld <= slot1_vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (refresh_req) begin
      slot0_bank <= slot0_bank_nxt;
      slot1_bank <= slot1_bank_nxt;
    end
  end

  // a refresh must never collide with a port access.
  a_cmd_not_blocked: assert property (
    @(posedge clk) `EDRAM_REFR_ASSERT_OFF
    refr_cmd.vld |-> !(acc_a.vld && (acc_a.bank == refr_cmd.bank)) &&
                     !(acc_b.vld && (acc_b.bank == refr_cmd.bank))
  );

  // slots fill and drain in order.
  a_slot_order: assert property (
    @(posedge clk) `EDRAM_REFR_ASSERT_OFF
    slot1_vld |-> slot0_vld
  );

endmodule

// ==== hdl/retention_monitor.sv ====
`include "edram_refr_defs.svh"

module retention_monitor
  import edram_refr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      refresh_req,
  input  refr_cmd_t refr_cmd,
  output overdue_t  overdue
);

  // requests seen since each bank's last refresh.
  logic [age_bits-1:0]  age [num_banks];
  logic [num_banks-1:0] refreshed;
  logic [num_banks-1:0] hit;
  logic [bank_bits-1:0] hit_bank;

  logic                 ov_vld;
  logic [bank_bits-1:0] ov_bank;

  always_comb begin
    refreshed = '0;
    if (refr_cmd.vld) begin
      refreshed[refr_cmd.bank] = 1'b1;
    end
  end

  // banks stepping onto the limit with this request.
  always_comb begin
    for (int i = 0; i < num_banks; i++) begin
      hit[i] = refresh_req && !refreshed[i] &&
               (age[i] == age_bits'(retention_limit - 1));
    end
  end

  // lowest bank wins.
  always_comb begin
    hit_bank = '0;
    for (int i = num_banks - 1; i >= 0; i--) begin
      if (hit[i]) begin
        hit_bank = bank_bits'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_banks; i++) begin
        age[i] <= '0;
      end
    end else if (refresh_req) begin
      for (int i = 0; i < num_banks; i++) begin
        if (refreshed[i]) begin
          age[i] <= '0;
        end else if (age[i] != age_bits'(retention_limit)) begin
          age[i] <= age[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ov_vld <= 1'b0;
    end else begin
      ov_vld <= |hit;
    end
  end

  always_ff @(posedge clk) begin
    ov_bank <= hit_bank;
  end

  assign overdue = '{vld: ov_vld, bank: ov_bank};

  // commands only come out of a refresh request.
  a_cmd_needs_req: assert property (
    @(posedge clk) `EDRAM_REFR_ASSERT_OFF
    refr_cmd.vld |-> refresh_req
  );

endmodule

// ==== include/edram_refr_defs.svh ====
`ifndef EDRAM_REFR_DEFS_SVH
`define EDRAM_REFR_DEFS_SVH

// properties are not evaluated while the controller is in reset.
`define EDRAM_REFR_ASSERT_OFF disable iff (rst)

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the refresh controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_edram_refr \
  -o sim_edram_refr > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_edram_refr > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi

exit 0
